// ==== dap_swj.f ====
logic/dap_swj_pkg.sv
logic/dap_swj_regs.sv
logic/dap_byte_collector.sv
logic/dap_swj_sequence.sv
logic/dap_swj_pins.sv
logic/dap_resp_writer.sv
logic/dap_swj.sv
dv/dap_swj_tb.sv

// ==== dv/dap_swj_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dap_swj_tb;
    logic                  clk;
    logic                  resetn;
    logic                  wr_en;
    logic                  rd_en;
    logic [11:0]           addr;
    logic [31:0]           wdata;
    logic [3:0]            byte_en;
    dap_swj_pkg::cmd_sel_t start;
    logic                  in_valid;
    logic [7:0]            in_data;
    logic                  seq_rsp_valid = 1'b0;
    dap_swj_pkg::seq_rsp_t seq_rsp = '0;
    logic [31:0]           rdata;
    dap_swj_pkg::swj_cfg_t cfg;
    logic                  swd_mode;
    logic                  in_ready;
    logic                  seq_req_valid;
    dap_swj_pkg::seq_req_t seq_req;
    logic                  ram_write_en;
    logic [9:0]            ram_write_addr;
    logic [7:0]            ram_write_data;
    logic [9:0]            packet_len;
    dap_swj_pkg::cmd_sel_t done;

    integer                seed = 32'h0a1db9b1;
    integer                model_seed = 32'h0a1db9b1;
    int                    errors = 0;
    int                    checks = 0;
    int                    rsp_delay = 0;
    logic [7:0]            rsp_byte = '0;
    logic [7:0]            stream[$];
    dap_swj_pkg::seq_op_t  exp_op[$];
    int                    exp_len[$];
    logic [63:0]           exp_data[$];
    logic [7:0]            exp_ram[$];     // response bytes, all at address 0

    dap_swj #(.ADDR_WIDTH(12), .BASE_ADDR(12'h000)) i_dut (
        .clk, .resetn, .wr_en, .rd_en, .addr, .wdata, .byte_en, .start,
        .in_valid, .in_data, .seq_rsp_valid, .seq_rsp,
        .rdata, .cfg, .swd_mode, .in_ready, .seq_req_valid, .seq_req,
        .ram_write_en, .ram_write_addr, .ram_write_data, .packet_len, .done
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    // expected sequencer requests, 64-bit chunks with little-endian bytes
    function automatic void ref_chunks(input int nbits, input logic [7:0] data_bytes[$]);
        int          left;
        int          pos;
        int          len;
        logic [63:0] word;
        left = nbits;
        pos  = 0;
        while (left > 0) begin
            len  = (left > 64) ? 64 : left;
            word = '0;
            for (int b = 0; b < (len + 7) / 8; b++) begin
                word[b*8 +: 8] = data_bytes[pos + b];
            end
            exp_op.push_back(dap_swj_pkg::SEQ_OP_SWD_SEQ);
            exp_len.push_back(len);
            exp_data.push_back(word);
            pos  = pos + (len + 7) / 8;
            left = left - len;
        end
    endfunction

    // sequencer model, replies after 1 to 8 cycles
    always @(posedge clk) begin
        seq_rsp_valid <= 1'b0;
        if (rsp_delay > 0) begin
            rsp_delay <= rsp_delay - 1;
            if (rsp_delay == 1) begin
                seq_rsp_valid <= 1'b1;
                seq_rsp.data  <= rsp_byte;
            end
        end
        if (resetn && seq_req_valid) begin
            rsp_delay <= 1 + ($random(model_seed) & 7);
            rsp_byte  <= seq_req.data[7:0] ^ 8'ha5;
        end
    end

    always @(posedge clk) begin
        if (resetn && seq_req_valid) begin
            $display("%0t ns request op %0d len %0d data %h", $time, seq_req.op,
                     seq_req.bit_len, seq_req.data);
            if (exp_op.size() == 0) begin
                errors++;
                $display("sequencer request at %0t ns was not expected", $time);
            end else begin
                check_val("seq_req.op", 64'(seq_req.op), 64'(exp_op.pop_front()));
                check_val("seq_req.bit_len", 64'(seq_req.bit_len), 64'(exp_len.pop_front()));
                check_val("seq_req.data", seq_req.data, exp_data.pop_front());
            end
        end
        if (resetn && ram_write_en) begin
            $display("%0t ns ram write addr %0d data %h", $time, ram_write_addr,
                     ram_write_data);
            if (exp_ram.size() == 0) begin
                errors++;
                $display("response write at %0t ns was not expected", $time);
            end else begin
                check_val("ram_write_addr", 64'(ram_write_addr), 64'd0);
                check_val("ram_write_data", 64'(ram_write_data), 64'(exp_ram.pop_front()));
            end
        end
    end

    task automatic bus_write(input logic [11:0] waddr, input logic [31:0] wval,
                             input logic [3:0] strb);
        @(posedge clk);
        wr_en   <= 1'b1;
        addr    <= waddr;
        wdata   <= wval;
        byte_en <= strb;
        @(posedge clk);
        wr_en   <= 1'b0;
    endtask

    task automatic bus_read_check(input logic [11:0] raddr, input logic [31:0] expected);
        @(posedge clk);
        rd_en <= 1'b1;
        addr  <= raddr;
        @(posedge clk);
        check_val("rdata", 64'(rdata), 64'(expected));
        rd_en <= 1'b0;
    endtask

    task automatic send_stream(input bit paced);
        int idx;
        int guard;
        idx   = 0;
        guard = 0;
        while (idx < stream.size()) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                idx++;
            end
            guard++;
            if (guard > 4000) begin
                errors++;
                $display("timeout: byte stream stalled at byte %0d", idx);
                in_valid <= 1'b0;
                return;
            end
            if (idx < stream.size() && (!paced || (($random(seed) & 1) == 0))) begin
                in_valid <= 1'b1;
                in_data  <= stream[idx];
            end else begin
                in_valid <= 1'b0;
            end
        end
    endtask

    task automatic wait_done(input dap_swj_pkg::cmd_sel_t cmd);
        int guard;
        guard = 0;
        do begin
            @(posedge clk);
            guard++;
            if (guard > 2000) begin
                errors++;
                $display("timeout: done never went high for the command");
                return;
            end
        end while (done !== cmd);
        check_val("ram_write_en", 64'(ram_write_en), 64'd1);   // final write with done
        check_val("packet_len", 64'(packet_len), 64'd1);
    endtask

    task automatic end_cmd(input dap_swj_pkg::cmd_sel_t cmd);
        @(posedge clk);
        check_val("done", 64'(done), 64'(cmd));    // held while start is high
        start <= '0;
        @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            check_val("done", 64'(done), 64'd0);
            check_val("ram_write_en", 64'(ram_write_en), 64'd0);
            check_val("seq_req_valid", 64'(seq_req_valid), 64'd0);
            check_val("in_ready", 64'(in_ready), 64'd0);
        end
        check_val("pending requests", 64'(exp_op.size()), 64'd0);
        check_val("pending ram writes", 64'(exp_ram.size()), 64'd0);
    endtask

    task automatic run_sequence(input logic [7:0] count, input bit paced);
        logic [7:0]            data_bytes[$];
        dap_swj_pkg::cmd_sel_t cmd;
        int                    nbits;
        nbits = (count == 8'd0) ? 256 : int'(count);
        cmd = '0;
        cmd.swj_sequence = 1'b1;
        for (int i = 0; i < (nbits + 7) / 8; i++) begin
            data_bytes.push_back(8'($random(seed)));
        end
        ref_chunks(nbits, data_bytes);
        exp_ram.push_back(dap_swj_pkg::DAP_OK);
        stream = data_bytes;
        stream.push_front(count);
        @(posedge clk);
        start <= cmd;
        send_stream(paced);
        wait_done(cmd);
        end_cmd(cmd);
    endtask

    task automatic run_pins(input bit paced);
        logic [7:0]            payload[$];
        logic [63:0]           word;
        dap_swj_pkg::cmd_sel_t cmd;
        word = '0;
        cmd = '0;
        cmd.swj_pins = 1'b1;
        for (int i = 0; i < 6; i++) begin      // output, select, 4-byte wait
            payload.push_back(8'($random(seed)));
            word[i*8 +: 8] = payload[i];
        end
        exp_op.push_back(dap_swj_pkg::SEQ_OP_SWJ_PINS);
        exp_len.push_back(0);
        exp_data.push_back(word);
        exp_ram.push_back(payload[0] ^ 8'ha5);
        stream = payload;
        @(posedge clk);
        start <= cmd;
        send_stream(paced);
        wait_done(cmd);
        end_cmd(cmd);
    endtask

    task automatic check_registers();
        bus_write(12'h000, 32'h0000_0001, 4'b1111);
        bus_read_check(12'h000, 32'h0000_0001);
        check_val("swd_mode", 64'(swd_mode), 64'd0);
        bus_write(12'h004, 32'h1234_5678, 4'b1111);
        bus_write(12'h004, 32'haabb_ccdd, 4'b0101);    // bytes 0 and 2 only
        bus_read_check(12'h004, 32'h12bb_56dd);
        check_val("cfg.wait_retry", 64'(cfg.wait_retry), 64'h56dd);
        check_val("cfg.match_retry", 64'(cfg.match_retry), 64'h12bb);
        bus_write(12'h008, 32'hffff_ff3c, 4'b0001);
        bus_write(12'h008, 32'hffff_ffff, 4'b0010);
        bus_read_check(12'h008, 32'h0000_013c);
        check_val("cfg.turn", 64'(cfg.turn), 64'h3c);
        check_val("cfg.force_data", 64'(cfg.force_data), 64'd1);
        bus_read_check(12'h00c, 32'h0);
        bus_read_check(12'h100, 32'h0);
        bus_write(12'h000, 32'h0000_0000, 4'b0001);
        bus_read_check(12'h000, 32'h0);
        check_val("swd_mode", 64'(swd_mode), 64'd1);
    endtask

    initial begin
        resetn   = 1'b0;
        wr_en    = 1'b0;
        rd_en    = 1'b0;
        addr     = '0;
        wdata    = '0;
        byte_en  = '0;
        start    = '0;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        check_val("done", 64'(done), 64'd0);
        check_val("ram_write_en", 64'(ram_write_en), 64'd0);
        check_val("seq_req_valid", 64'(seq_req_valid), 64'd0);
        check_val("packet_len", 64'(packet_len), 64'd0);
        check_val("cfg", 64'(cfg), 64'd0);
        check_val("in_ready", 64'(in_ready), 64'd0);
        check_registers();
        run_sequence(8'd0, 1'b0);      // 256 bits
        run_sequence(8'd37, 1'b0);     // upper bytes must come back zero
        run_sequence(8'd150, 1'b1);
        run_pins(1'b1);
        end_run();
    end

endmodule

`default_nettype wire

// ==== logic/dap_byte_collector.sv ====
`timescale 1ns/100ps
`default_nettype none

module dap_byte_collector (
    input  wire         clk,
    input  wire         resetn,
    input  wire         start,
    input  wire  [6:0]  bits,
    input  wire         in_valid,
    input  wire  [7:0]  in_data,
    input  wire         owner_active,
    output logic        in_ready,
    output logic [63:0] data,
    output logic        finish
);
    logic [7:0] bits_up;
    logic [3:0] need;
    logic [3:0] need_q;
    logic [3:0] idx;
    logic [3:0] idx_q;
    logic       finish_q;
    logic       take;

    assign bits_up  = {1'b0, bits} + 8'd7;
    assign need     = start ? bits_up[6:3] : need_q;   // bytes owed
    assign idx      = start ? 4'd0 : idx_q;
    assign in_ready = owner_active && (!finish_q || start);
    assign take     = in_valid && in_ready;
    assign finish   = finish_q && !start;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            idx_q    <= '0;
            need_q   <= '0;
            finish_q <= 1'b1;
        end else if (!owner_active) begin
            finish_q <= 1'b1;                         // no command, nothing owed
        end else begin
            if (start) begin
                idx_q    <= '0;
                need_q   <= need;
                finish_q <= 1'b0;
            end
            if (take) begin
                idx_q <= idx + 4'd1;
                if (idx + 4'd1 >= need) begin
                    finish_q <= 1'b1;
                end
            end
        end
    end

    // little-endian; untouched bytes stay zero
    always_ff @(posedge clk) begin
        if (start) begin
            data <= '0;
        end
        if (take) begin
            data[{idx[2:0], 3'b000} +: 8] <= in_data;
        end
    end

    a_idx_range: assert property (@(posedge clk) disable iff (!resetn) take |-> idx < 4'd8);

endmodule

`default_nettype wire

// ==== logic/dap_resp_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module dap_resp_writer (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire  dap_swj_pkg::cmd_sel_t start,
    input  wire  dap_swj_pkg::resp_wr_t seq_wr,
    input  wire  dap_swj_pkg::resp_wr_t pins_wr,
    output logic                    ram_write_en,
    output logic [9:0]              ram_write_addr,
    output logic [7:0]              ram_write_data,
    output logic [9:0]              packet_len,
    output dap_swj_pkg::cmd_sel_t   done
);
    dap_swj_pkg::resp_wr_t wr;

    assign wr = start.swj_pins ? pins_wr : seq_wr;   // active handler

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ram_write_en <= 1'b0;
            packet_len   <= '0;
            done         <= '0;
        end else begin
            ram_write_en <= wr.en;
            done         <= dap_swj_pkg::cmd_sel_t'(done & start);   // clears as start drops
            if (wr.en && wr.last) begin
                packet_len <= wr.len;
                done       <= start;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.en) begin
            ram_write_addr <= wr.addr;
            ram_write_data <= wr.data;
        end
    end

    a_start_onehot: assert property (@(posedge clk) disable iff (!resetn) $onehot0(start));
    a_one_writer: assert property (@(posedge clk) disable iff (!resetn)
        !(seq_wr.en && pins_wr.en));

endmodule

`default_nettype wire

// ==== logic/dap_swj.sv ====
`timescale 1ns/100ps
`default_nettype none

module dap_swj #(
    parameter int                    ADDR_WIDTH = 12,
    parameter logic [ADDR_WIDTH-1:0] BASE_ADDR  = '0
) (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     wr_en,
    input  wire                     rd_en,
    input  wire  [ADDR_WIDTH-1:0]   addr,
    input  wire  [31:0]             wdata,
    input  wire  [3:0]              byte_en,
    input  wire  dap_swj_pkg::cmd_sel_t start,
    input  wire                     in_valid,
    input  wire  [7:0]              in_data,
    input  wire                     seq_rsp_valid,
    input  wire  dap_swj_pkg::seq_rsp_t seq_rsp,
    output logic [31:0]             rdata,
    output dap_swj_pkg::swj_cfg_t   cfg,
    output logic                    swd_mode,
    output logic                    in_ready,
    output logic                    seq_req_valid,
    output dap_swj_pkg::seq_req_t   seq_req,
    output logic                    ram_write_en,
    output logic [9:0]              ram_write_addr,
    output logic [7:0]              ram_write_data,
    output logic [9:0]              packet_len,
    output dap_swj_pkg::cmd_sel_t   done
);
    logic                  sq_in_ready, pn_in_ready;
    logic                  sq_coll_start, pn_coll_start;
    logic [6:0]            sq_coll_bits, pn_coll_bits;
    logic                  sq_req_valid, pn_req_valid;
    dap_swj_pkg::seq_req_t sq_req, pn_req;
    dap_swj_pkg::resp_wr_t sq_wr, pn_wr;
    logic                  coll_ready, coll_finish;
    logic [63:0]           coll_data;

    // idle handler drives zeros
    assign in_ready      = sq_in_ready | pn_in_ready;
    assign seq_req_valid = sq_req_valid | pn_req_valid;
    assign seq_req       = dap_swj_pkg::seq_req_t'(sq_req | pn_req);
    assign swd_mode      = ~cfg.jtag_mode;

    dap_swj_regs #(.ADDR_WIDTH(ADDR_WIDTH), .BASE_ADDR(BASE_ADDR)) i_regs (
        .clk, .resetn, .wr_en, .rd_en, .addr, .wdata, .byte_en, .rdata, .cfg
    );

    dap_byte_collector i_collector (
        .clk, .resetn,
        .start(sq_coll_start | pn_coll_start), .bits(sq_coll_bits | pn_coll_bits),
        .in_valid, .in_data, .owner_active(start.swj_sequence | start.swj_pins),
        .in_ready(coll_ready), .data(coll_data), .finish(coll_finish)
    );

    dap_swj_sequence i_sequence (
        .clk, .resetn, .start(start.swj_sequence), .in_valid, .in_data,
        .coll_ready, .coll_data, .coll_finish, .seq_rsp_valid,
        .in_ready(sq_in_ready), .coll_start(sq_coll_start), .coll_bits(sq_coll_bits),
        .seq_req_valid(sq_req_valid), .seq_req(sq_req), .resp(sq_wr)
    );

    dap_swj_pins i_pins (
        .clk, .resetn, .start(start.swj_pins), .coll_ready, .coll_data, .coll_finish,
        .seq_rsp_valid, .seq_rsp,
        .in_ready(pn_in_ready), .coll_start(pn_coll_start), .coll_bits(pn_coll_bits),
        .seq_req_valid(pn_req_valid), .seq_req(pn_req), .resp(pn_wr)
    );

    dap_resp_writer i_resp (
        .clk, .resetn, .start, .seq_wr(sq_wr), .pins_wr(pn_wr),
        .ram_write_en, .ram_write_addr, .ram_write_data, .packet_len, .done
    );

endmodule

`default_nettype wire

// ==== logic/dap_swj_pins.sv ====
`timescale 1ns/100ps
`default_nettype none

module dap_swj_pins (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     start,
    input  wire                     coll_ready,
    input  wire  [63:0]             coll_data,
    input  wire                     coll_finish,
    input  wire                     seq_rsp_valid,
    input  wire  dap_swj_pkg::seq_rsp_t seq_rsp,
    output logic                    in_ready,
    output logic                    coll_start,
    output logic [6:0]              coll_bits,
    output logic                    seq_req_valid,
    output dap_swj_pkg::seq_req_t   seq_req,
    output dap_swj_pkg::resp_wr_t   resp
);
    typedef enum logic [1:0] {S_START, S_COLLECT, S_WAIT, S_DONE} state_t;

    state_t state;

    assign in_ready = start && coll_ready;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state         <= S_START;
            coll_start    <= 1'b0;
            coll_bits     <= '0;
            seq_req_valid <= 1'b0;
            seq_req       <= '0;
            resp          <= '0;
        end else if (!start) begin
            state         <= S_START;
            coll_start    <= 1'b0;
            coll_bits     <= '0;
            seq_req_valid <= 1'b0;
            seq_req       <= '0;
            resp          <= '0;
        end else begin
            coll_start    <= 1'b0;
            seq_req_valid <= 1'b0;
            resp.en       <= 1'b0;
            case (state)
                S_START: begin
                    coll_start <= 1'b1;
                    coll_bits  <= 7'(dap_swj_pkg::PINS_BITS);  // output, select, wait
                    state      <= S_COLLECT;
                end
                S_COLLECT: if (coll_finish) begin
                    seq_req_valid   <= 1'b1;
                    seq_req.op      <= dap_swj_pkg::SEQ_OP_SWJ_PINS;
                    seq_req.bit_len <= '0;
                    seq_req.data    <= 64'(coll_data[dap_swj_pkg::PINS_BITS-1:0]);
                    state           <= S_WAIT;
                end
                S_WAIT: if (seq_rsp_valid) begin
                    resp  <= '{en: 1'b1, addr: 10'd0, data: seq_rsp.data,
                               last: 1'b1, len: 10'd1};
                    state <= S_DONE;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/dap_swj_pkg.sv ====
`default_nettype none

package dap_swj_pkg;

    typedef enum logic [1:0] {
        SEQ_OP_SWD_SEQ  = 2'd0,
        SEQ_OP_SWJ_PINS = 2'd1
    } seq_op_t;

    typedef struct packed {
        seq_op_t     op;
        logic [6:0]  bit_len;    // 1..64, unused for pins
        logic [63:0] data;
    } seq_req_t;

    typedef struct packed {
        logic [7:0] data;        // pin readback
    } seq_rsp_t;

    typedef struct packed {
        logic        jtag_mode;
        logic [15:0] wait_retry;
        logic [15:0] match_retry;
        logic [7:0]  turn;
        logic        force_data;
    } swj_cfg_t;

    typedef struct packed {
        logic       en;
        logic [9:0] addr;
        logic [7:0] data;
        logic       last;
        logic [9:0] len;
    } resp_wr_t;

    typedef struct packed {
        logic swj_sequence;
        logic swj_pins;
    } cmd_sel_t;

    localparam logic [7:0] DAP_OK = 8'h00;

    localparam int REG_CR_OFS     = 0;
    localparam int REG_RETRY_OFS  = 1;
    localparam int REG_SWD_CR_OFS = 2;

    localparam int PINS_BITS      = 48;
    localparam int MAX_CHUNK_BITS = 64;

endpackage

`default_nettype wire

// ==== logic/dap_swj_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module dap_swj_regs #(
    parameter int                    ADDR_WIDTH = 12,
    parameter logic [ADDR_WIDTH-1:0] BASE_ADDR  = '0
) (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    wr_en,
    input  wire                    rd_en,
    input  wire [ADDR_WIDTH-1:0]   addr,
    input  wire [31:0]             wdata,
    input  wire [3:0]              byte_en,
    output logic [31:0]            rdata,
    output dap_swj_pkg::swj_cfg_t  cfg
);
    logic [ADDR_WIDTH-1:0] rel_addr;
    logic [ADDR_WIDTH-3:0] word;
    logic                  hit_cr;
    logic                  hit_retry;
    logic                  hit_swd;
    logic                  jtag_mode;
    logic [31:0]           retry;      // match in high half
    logic [8:0]            swd_cr;

    assign rel_addr  = addr - BASE_ADDR;
    assign word      = rel_addr[ADDR_WIDTH-1:2];
    assign hit_cr    = word == (ADDR_WIDTH-2)'(dap_swj_pkg::REG_CR_OFS);
    assign hit_retry = word == (ADDR_WIDTH-2)'(dap_swj_pkg::REG_RETRY_OFS);
    assign hit_swd   = word == (ADDR_WIDTH-2)'(dap_swj_pkg::REG_SWD_CR_OFS);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            jtag_mode <= 1'b0;
            retry     <= '0;
            swd_cr    <= '0;
        end else if (wr_en) begin
            if (hit_cr && byte_en[0]) begin
                jtag_mode <= wdata[0];
            end
            for (int b = 0; b < 4; b++) begin
                if (hit_retry && byte_en[b]) begin
                    retry[b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
            if (hit_swd && byte_en[0]) begin
                swd_cr[7:0] <= wdata[7:0];    // turnaround
            end
            if (hit_swd && byte_en[1]) begin
                swd_cr[8] <= wdata[8];        // force data phase
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (rd_en && hit_cr) begin
            rdata = {31'd0, jtag_mode};
        end else if (rd_en && hit_retry) begin
            rdata = retry;
        end else if (rd_en && hit_swd) begin
            rdata = {23'd0, swd_cr};
        end
    end

    assign cfg.jtag_mode   = jtag_mode;
    assign cfg.wait_retry  = retry[15:0];
    assign cfg.match_retry = retry[31:16];
    assign cfg.turn        = swd_cr[7:0];
    assign cfg.force_data  = swd_cr[8];

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!resetn) !(wr_en && rd_en));

endmodule

`default_nettype wire

// ==== logic/dap_swj_sequence.sv ====
`timescale 1ns/100ps
`default_nettype none

module dap_swj_sequence (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     start,
    input  wire                     in_valid,
    input  wire  [7:0]              in_data,
    input  wire                     coll_ready,
    input  wire  [63:0]             coll_data,
    input  wire                     coll_finish,
    input  wire                     seq_rsp_valid,
    output logic                    in_ready,
    output logic                    coll_start,
    output logic [6:0]              coll_bits,
    output logic                    seq_req_valid,
    output dap_swj_pkg::seq_req_t   seq_req,
    output dap_swj_pkg::resp_wr_t   resp
);
    typedef enum logic [1:0] {S_COUNT, S_COLLECT, S_WAIT, S_DONE} state_t;

    state_t     state;
    logic [8:0] rem_q;       // bits left, chunk in flight included
    logic [8:0] rem_in;
    logic [8:0] rem_left;
    logic [8:0] rem_sel;
    logic [6:0] chunk;

    assign rem_in   = (in_data == 8'd0) ? 9'd256 : {1'b0, in_data};
    assign rem_left = rem_q - {2'b00, coll_bits};
    assign rem_sel  = (state == S_COUNT) ? rem_in : rem_left;
    assign chunk    = (rem_sel > 9'(dap_swj_pkg::MAX_CHUNK_BITS)) ?
                      7'(dap_swj_pkg::MAX_CHUNK_BITS) : rem_sel[6:0];
    assign in_ready = start && (state == S_COUNT || coll_ready);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state         <= S_COUNT;
            rem_q         <= '0;
            coll_start    <= 1'b0;
            coll_bits     <= '0;
            seq_req_valid <= 1'b0;
            seq_req       <= '0;
            resp          <= '0;
        end else if (!start) begin
            state         <= S_COUNT;
            coll_start    <= 1'b0;
            coll_bits     <= '0;
            seq_req_valid <= 1'b0;
            seq_req       <= '0;
            resp          <= '0;
        end else begin
            coll_start    <= 1'b0;
            seq_req_valid <= 1'b0;
            resp.en       <= 1'b0;
            case (state)
                S_COUNT: if (in_valid) begin
                    rem_q      <= rem_in;
                    coll_start <= 1'b1;
                    coll_bits  <= chunk;
                    state      <= S_COLLECT;
                end
                S_COLLECT: if (coll_finish) begin
                    seq_req_valid   <= 1'b1;
                    seq_req.op      <= dap_swj_pkg::SEQ_OP_SWD_SEQ;
                    seq_req.bit_len <= coll_bits;
                    seq_req.data    <= coll_data;
                    rem_q           <= rem_left;
                    if (rem_left != 9'd0) begin   // gather next chunk meanwhile
                        coll_start <= 1'b1;
                        coll_bits  <= chunk;
                    end
                    state <= S_WAIT;
                end
                S_WAIT: if (seq_rsp_valid) begin
                    if (rem_q == 9'd0) begin
                        resp  <= '{en: 1'b1, addr: 10'd0, data: dap_swj_pkg::DAP_OK,
                                   last: 1'b1, len: 10'd1};
                        state <= S_DONE;
                    end else begin
                        state <= S_COLLECT;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the dap_swj testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f dap_swj.f --top-module dap_swj_tb -Mdir build -o dap_swj_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./build/dap_swj_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
fi
exit 1
